//--- rtl/chdr_ingress_defs.svh
`ifndef CHDR_INGRESS_DEFS_SVH
`define CHDR_INGRESS_DEFS_SVH

// ----------------------------------------
// Ingress stage sizing
// ----------------------------------------

// Beat width, fixed by the CHDR header layout
`define CHDR_WIDTH 64

// Log2 of packet buffer depth in beats
`define CHDR_MTU_LOG2 5

// Width of a crossbar destination port
`define CHDR_DEST_W 4

// Rows in the routing table
`define ROUTE_ENTRIES 8

`endif

//--- rtl/chdr_ingress_pkg.sv
`include "chdr_ingress_defs.svh"

package chdr_ingress_pkg;

  // ----------------------------------------
  // Stream payloads
  // ----------------------------------------

  // One packet beat
  typedef struct packed {
    logic [`CHDR_WIDTH-1:0] data;
    logic                   last;
  } chdr_beat_t;

  // Route mode tag on the header beat, 3 is reserved
  typedef enum logic [1:0] {
    ROUTE_EPID    = 2'd0,
    ROUTE_TDEST   = 2'd1,
    RETURN_TO_SRC = 2'd2
  } route_mode_e;

  // Destination decided for one packet
  typedef struct packed {
    logic                    keep;
    logic [`CHDR_DEST_W-1:0] port;
  } route_result_t;

  // One routing table row
  typedef struct packed {
    logic                    valid;
    logic [15:0]             epid;
    logic [`CHDR_DEST_W-1:0] port;
  } route_entry_t;

  // Destination EPID sits in the low 16 bits of the first beat
  function automatic logic [15:0] get_dst_epid(input logic [`CHDR_WIDTH-1:0] hdr);
    return hdr[15:0];
  endfunction

endpackage

//--- rtl/axis_stream_if.sv
`timescale 1ns/1ps

// Valid/ready stream carrying one payload per transfer
// Transfer on a clock edge with valid and ready both high
// Valid and payload hold from rising valid until the transfer
interface axis_stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t payload;

  // ----------------------------------------
  // Modports
  // ----------------------------------------

  // Producer side
  modport source (
    output valid,
    output payload,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  payload,
    output ready
  );

  // Passive observer, sees every transfer
  modport monitor (
    input valid,
    input payload,
    input ready
  );

endinterface

//--- rtl/chdr_pkt_gate.sv
`timescale 1ns/1ps
`include "chdr_ingress_defs.svh"

// Store-and-forward buffer
// A packet is visible on the output only once its last beat is stored
module chdr_pkt_gate (
  input  logic         clk,
  input  logic         reset,
  input  logic         i_route_room,
  axis_stream_if.sink   s_in,
  axis_stream_if.source m_out
);

  localparam int AW    = `CHDR_MTU_LOG2;
  localparam int DEPTH = 1 << AW;

  // ----------------------------------------
  // Storage and pointers
  // ----------------------------------------

  chdr_ingress_pkg::chdr_beat_t mem [DEPTH];

  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] commit_ptr;
  logic [AW:0] used;

  logic        full;
  logic        hdr_next;
  logic        in_stb;
  logic        out_stb;

  // Occupancy never exceeds DEPTH, so the MSB alone flags full
  assign used = wr_ptr - rd_ptr;
  assign full = used[AW];

  // ----------------------------------------
  // Input side
  // ----------------------------------------

  // Header beats also need a free slot in the route queue
  assign s_in.ready = !full && (!hdr_next || i_route_room);
  assign in_stb     = s_in.valid && s_in.ready;

  // Next accepted beat is a header after a last beat
  always_ff @(posedge clk) begin
    if (reset) begin
      hdr_next <= 1'b1;
    end else if (in_stb) begin
      hdr_next <= s_in.payload.last;
    end
  end

  // Beat memory write
  always_ff @(posedge clk) begin
    if (in_stb) begin
      mem[wr_ptr[AW-1:0]] <= s_in.payload;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
    end else if (in_stb) begin
      wr_ptr <= wr_ptr + 1'b1;
      // Whole packet now stored, release it
      if (s_in.payload.last) begin
        commit_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Output side
  // ----------------------------------------

  // Only committed beats are presented
  assign m_out.valid   = (rd_ptr != commit_ptr);
  assign m_out.payload = mem[rd_ptr[AW-1:0]];
  assign out_stb       = m_out.valid && m_out.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (out_stb) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- rtl/chdr_route_resolver.sv
`timescale 1ns/1ps
`include "chdr_ingress_defs.svh"

// Decides the destination of each packet from its header beat
// Results queue up in arrival order, one per packet
module chdr_route_resolver #(
  parameter logic [`CHDR_DEST_W-1:0] NODE_PORT = '0
) (
  input  logic                                clk,
  input  logic                                reset,
  input  chdr_ingress_pkg::route_mode_e       i_mode,
  input  logic [`CHDR_DEST_W-1:0]             i_tdest,
  // Routing table write port
  input  logic                                i_cfg_wr,
  input  logic [$clog2(`ROUTE_ENTRIES)-1:0]   i_cfg_index,
  input  logic                                i_cfg_valid,
  input  logic [15:0]                         i_cfg_epid,
  input  logic [`CHDR_DEST_W-1:0]             i_cfg_port,
  axis_stream_if.monitor                      s_mon,
  output logic                                o_route_room,
  axis_stream_if.source                       m_route
);

  // ----------------------------------------
  // Routing table
  // ----------------------------------------

  chdr_ingress_pkg::route_entry_t route_table [`ROUTE_ENTRIES];

  // A write shows up in lookups on the following cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `ROUTE_ENTRIES; i++) begin
        route_table[i] <= '0;
      end
    end else if (i_cfg_wr) begin
      route_table[i_cfg_index].valid <= i_cfg_valid;
      route_table[i_cfg_index].epid  <= i_cfg_epid;
      route_table[i_cfg_index].port  <= i_cfg_port;
    end
  end

  // ----------------------------------------
  // Header tracking
  // ----------------------------------------

  logic        hdr_next;
  logic        hdr_stb;
  logic [15:0] hdr_epid;

  always_ff @(posedge clk) begin
    if (reset) begin
      hdr_next <= 1'b1;
    end else if (s_mon.valid && s_mon.ready) begin
      hdr_next <= s_mon.payload.last;
    end
  end

  assign hdr_stb  = s_mon.valid && s_mon.ready && hdr_next;
  assign hdr_epid = chdr_ingress_pkg::get_dst_epid(s_mon.payload.data);

  // ----------------------------------------
  // Lookup and mode decode
  // ----------------------------------------

  chdr_ingress_pkg::route_result_t lookup;
  chdr_ingress_pkg::route_result_t route_next;

  // Scan downward so the lowest matching index wins
  always_comb begin
    lookup.keep = 1'b0;
    lookup.port = '0;
    for (int i = `ROUTE_ENTRIES - 1; i >= 0; i--) begin
      if (route_table[i].valid && (route_table[i].epid == hdr_epid)) begin
        lookup.keep = 1'b1;
        lookup.port = route_table[i].port;
      end
    end
  end

  always_comb begin
    case (i_mode)
      chdr_ingress_pkg::ROUTE_EPID: begin
        route_next = lookup;
      end
      chdr_ingress_pkg::ROUTE_TDEST: begin
        route_next.keep = 1'b1;
        route_next.port = i_tdest;
      end
      // Return to source, reserved code treated the same
      default: begin
        route_next.keep = 1'b1;
        route_next.port = NODE_PORT;
      end
    endcase
  end

  // ----------------------------------------
  // Two-entry result queue
  // ----------------------------------------

  chdr_ingress_pkg::route_result_t q_mem [2];

  logic       q_wr_idx;
  logic       q_rd_idx;
  logic [1:0] q_count;
  logic       q_pop;

  assign q_pop           = m_route.valid && m_route.ready;
  assign m_route.valid   = (q_count != 2'd0);
  assign m_route.payload = q_mem[q_rd_idx];
  // Gate only lets a header through while this is high
  assign o_route_room    = !q_count[1];

  always_ff @(posedge clk) begin
    if (hdr_stb) begin
      q_mem[q_wr_idx] <= route_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      q_wr_idx <= 1'b0;
      q_rd_idx <= 1'b0;
      q_count  <= 2'd0;
    end else begin
      if (hdr_stb) q_wr_idx <= !q_wr_idx;
      if (q_pop)   q_rd_idx <= !q_rd_idx;
      case ({hdr_stb, q_pop})
        2'b10:   q_count <= q_count + 2'd1;
        2'b01:   q_count <= q_count - 2'd1;
        default: q_count <= q_count;
      endcase
    end
  end

endmodule

//--- rtl/chdr_dest_join.sv
`timescale 1ns/1ps
`include "chdr_ingress_defs.svh"

// Attaches the queued route result to each released packet
// Destination stays fixed until the last beat leaves
module chdr_dest_join (
  axis_stream_if.sink              s_pkt,
  axis_stream_if.sink              s_route,
  output logic [`CHDR_WIDTH-1:0]   o_tdata,
  output logic                     o_tlast,
  output logic [`CHDR_DEST_W-1:0]  o_tdest,
  output logic                     o_tkeep,
  output logic                     o_tvalid,
  input  logic                     i_tready
);

  logic out_stb;

  // ----------------------------------------
  // Output beat
  // ----------------------------------------

  // Packet beat alone is not enough, the route must be known
  assign o_tvalid = s_pkt.valid && s_route.valid;
  assign out_stb  = o_tvalid && i_tready;

  assign o_tdata = s_pkt.payload.data;
  assign o_tlast = s_pkt.payload.last;
  assign o_tdest = s_route.payload.port;
  assign o_tkeep = s_route.payload.keep;

  // ----------------------------------------
  // Consume
  // ----------------------------------------

  // Every output transfer takes one packet beat
  assign s_pkt.ready = out_stb;

  // Route result retires with the last beat of its packet
  assign s_route.ready = out_stb && s_pkt.payload.last;

endmodule

//--- rtl/chdr_ingress_top.sv
`timescale 1ns/1ps
`include "chdr_ingress_defs.svh"

// Ingress stage of one crossbar port
// Packet gate and route resolver see the same input beats
module chdr_ingress_top #(
  parameter logic [`CHDR_DEST_W-1:0] NODE_PORT = '0
) (
  input  logic                              clk,
  input  logic                              reset,
  // Packet input
  input  logic [`CHDR_WIDTH-1:0]            i_s_tdata,
  input  logic                              i_s_tlast,
  input  logic [1:0]                        i_s_tmode,
  input  logic [`CHDR_DEST_W-1:0]           i_s_tdest,
  input  logic                              i_s_tvalid,
  output logic                              o_s_tready,
  // Routing table write port
  input  logic                              i_cfg_wr,
  input  logic [$clog2(`ROUTE_ENTRIES)-1:0] i_cfg_index,
  input  logic                              i_cfg_valid,
  input  logic [15:0]                       i_cfg_epid,
  input  logic [`CHDR_DEST_W-1:0]           i_cfg_port,
  // Packet output with destination
  output logic [`CHDR_WIDTH-1:0]            o_m_tdata,
  output logic                              o_m_tlast,
  output logic [`CHDR_DEST_W-1:0]           o_m_tdest,
  output logic                              o_m_tkeep,
  output logic                              o_m_tvalid,
  input  logic                              i_m_tready
);

  // ----------------------------------------
  // Internal streams
  // ----------------------------------------

  axis_stream_if #(.payload_t(chdr_ingress_pkg::chdr_beat_t))    in_beats ();
  axis_stream_if #(.payload_t(chdr_ingress_pkg::chdr_beat_t))    gate_out ();
  axis_stream_if #(.payload_t(chdr_ingress_pkg::route_result_t)) route_q  ();

  logic route_room;

  // Input pins onto the shared stream
  assign in_beats.valid        = i_s_tvalid;
  assign in_beats.payload.data = i_s_tdata;
  assign in_beats.payload.last = i_s_tlast;
  assign o_s_tready            = in_beats.ready;

  // ----------------------------------------
  // Blocks
  // ----------------------------------------

  chdr_pkt_gate u_gate (
    .clk          (clk),
    .reset        (reset),
    .i_route_room (route_room),
    .s_in         (in_beats.sink),
    .m_out        (gate_out.source)
  );

  chdr_route_resolver #(.NODE_PORT(NODE_PORT)) u_resolver (
    .clk          (clk),
    .reset        (reset),
    .i_mode       (chdr_ingress_pkg::route_mode_e'(i_s_tmode)),
    .i_tdest      (i_s_tdest),
    .i_cfg_wr     (i_cfg_wr),
    .i_cfg_index  (i_cfg_index),
    .i_cfg_valid  (i_cfg_valid),
    .i_cfg_epid   (i_cfg_epid),
    .i_cfg_port   (i_cfg_port),
    .s_mon        (in_beats.monitor),
    .o_route_room (route_room),
    .m_route      (route_q.source)
  );

  chdr_dest_join u_join (
    .s_pkt    (gate_out.sink),
    .s_route  (route_q.sink),
    .o_tdata  (o_m_tdata),
    .o_tlast  (o_m_tlast),
    .o_tdest  (o_m_tdest),
    .o_tkeep  (o_m_tkeep),
    .o_tvalid (o_m_tvalid),
    .i_tready (i_m_tready)
  );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

// Free-running clock and a synchronous reset pulse for the testbench
module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset held for a whole number of rising edges, released on a falling edge
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset = 1'b0;
  end

endmodule

//--- testbench/chdr_ingress_asserts.sv
`timescale 1ns/1ps
`include "chdr_ingress_defs.svh"

// Protocol checks on the ingress output stream
module chdr_ingress_asserts (
  input logic                    clk,
  input logic                    reset,
  input logic                    i_valid,
  input logic                    i_ready,
  input logic [`CHDR_WIDTH-1:0]  i_data,
  input logic                    i_last,
  input logic [`CHDR_DEST_W-1:0] i_dest,
  input logic                    i_keep
);

  // Number of assertion failures so far
  int fail_count = 0;

  // ----------------------------------------
  // Stall and packet rules
  // ----------------------------------------

  // A stalled beat keeps valid, data and routing until taken
  stall_hold : assert property (@(posedge clk) disable iff (reset)
    (i_valid && !i_ready) |=>
      (i_valid && $stable(i_data) && $stable(i_last) && $stable(i_dest) && $stable(i_keep)))
    else begin
      $error("Output beat changed while stalled");
      fail_count++;
    end

  // Whole packet sits in the gate, so its beats follow without gaps
  // Destination and keep carry over from beat to beat
  dest_steady : assert property (@(posedge clk) disable iff (reset)
    (i_valid && i_ready && !i_last) |=> ($stable(i_dest) && $stable(i_keep)))
    else begin
      $error("Destination or keep changed inside a packet");
      fail_count++;
    end

endmodule

//--- testbench/chdr_ingress_tb.sv
`timescale 1ns/1ps
`include "chdr_ingress_defs.svh"

module chdr_ingress_tb;

  localparam logic [`CHDR_DEST_W-1:0] NODE_PORT = 4'd9;
  localparam logic [31:0] SEED = 32'd32;
  localparam int CLK_PERIOD_NS = 20;
  // Beats over all tests with back-pressure packets counted at full length
  localparam int TEST_BEATS = 3 + 6 + 6 + 16 + 20 * 32;

  logic                              clk;
  logic                              reset;
  logic [`CHDR_WIDTH-1:0]            i_s_tdata;
  logic                              i_s_tlast;
  logic [1:0]                        i_s_tmode;
  logic [`CHDR_DEST_W-1:0]           i_s_tdest;
  logic                              i_s_tvalid;
  logic                              o_s_tready;
  logic                              i_cfg_wr;
  logic [$clog2(`ROUTE_ENTRIES)-1:0] i_cfg_index;
  logic                              i_cfg_valid;
  logic [15:0]                       i_cfg_epid;
  logic [`CHDR_DEST_W-1:0]           i_cfg_port;
  logic [`CHDR_WIDTH-1:0]            o_m_tdata;
  logic                              o_m_tlast;
  logic [`CHDR_DEST_W-1:0]           o_m_tdest;
  logic                              o_m_tkeep;
  logic                              o_m_tvalid;
  logic                              i_m_tready = 1'b1;

  // Scoreboard holds one entry per expected output beat
  chdr_ingress_pkg::chdr_beat_t    exp_beat [$];
  chdr_ingress_pkg::route_result_t exp_route [$];

  // Copy of what has been written to the routing table
  logic                    shadow_valid [`ROUTE_ENTRIES];
  logic [15:0]             shadow_epid [`ROUTE_ENTRIES];
  logic [`CHDR_DEST_W-1:0] shadow_port [`ROUTE_ENTRIES];

  logic [31:0] stim_state = SEED;
  logic [31:0] rdy_state  = ~SEED;
  logic        rdy_random = 1'b0;
  logic        out_first  = 1'b1;
  int          errors     = 0;
  int          checks     = 0;
  int          in_pkts    = 0;
  int          out_pkts   = 0;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) u_clk (
    .o_clk   (clk),
    .o_reset (reset)
  );

  chdr_ingress_top #(.NODE_PORT(NODE_PORT)) i_dut (
    .clk (clk), .reset (reset),
    .i_s_tdata (i_s_tdata), .i_s_tlast (i_s_tlast), .i_s_tmode (i_s_tmode),
    .i_s_tdest (i_s_tdest), .i_s_tvalid (i_s_tvalid), .o_s_tready (o_s_tready),
    .i_cfg_wr (i_cfg_wr), .i_cfg_index (i_cfg_index), .i_cfg_valid (i_cfg_valid),
    .i_cfg_epid (i_cfg_epid), .i_cfg_port (i_cfg_port),
    .o_m_tdata (o_m_tdata), .o_m_tlast (o_m_tlast), .o_m_tdest (o_m_tdest),
    .o_m_tkeep (o_m_tkeep), .o_m_tvalid (o_m_tvalid), .i_m_tready (i_m_tready)
  );

  bind chdr_ingress_top chdr_ingress_asserts u_asserts (
    .clk (clk), .reset (reset), .i_valid (o_m_tvalid), .i_ready (i_m_tready),
    .i_data (o_m_tdata), .i_last (o_m_tlast), .i_dest (o_m_tdest), .i_keep (o_m_tkeep)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = lcg_step(stim_state);
    return stim_state;
  endfunction

  // Expected destination from tdest, the lowest valid EPID match or the own port
  function automatic chdr_ingress_pkg::route_result_t expected_route(
    input logic [1:0] mode, input logic [`CHDR_DEST_W-1:0] tdest, input logic [15:0] epid);
    chdr_ingress_pkg::route_result_t res;
    res.keep = 1'b1;
    res.port = NODE_PORT;
    if (mode == chdr_ingress_pkg::ROUTE_TDEST) begin
      res.port = tdest;
    end else if (mode == chdr_ingress_pkg::ROUTE_EPID) begin
      res.keep = 1'b0;
      res.port = '0;
      for (int i = 0; i < `ROUTE_ENTRIES; i++) begin
        if (!res.keep && shadow_valid[i] && (shadow_epid[i] == epid)) begin
          res.keep = 1'b1;
          res.port = shadow_port[i];
        end
      end
    end
    return res;
  endfunction

  task automatic write_route(input logic [$clog2(`ROUTE_ENTRIES)-1:0] index,
                             input logic valid, input logic [15:0] epid,
                             input logic [`CHDR_DEST_W-1:0] port);
    @(negedge clk);
    i_cfg_wr    = 1'b1;
    i_cfg_index = index;
    i_cfg_valid = valid;
    i_cfg_epid  = epid;
    i_cfg_port  = port;
    shadow_valid[index] = valid;
    shadow_epid[index]  = epid;
    shadow_port[index]  = port;
    @(negedge clk);
    i_cfg_wr = 1'b0;
  endtask

  // Header carries the destination EPID in its low 16 bits
  task automatic send_packet(input logic [1:0] mode, input logic [`CHDR_DEST_W-1:0] tdest,
                             input logic [15:0] epid, input int len);
    chdr_ingress_pkg::chdr_beat_t    beat;
    chdr_ingress_pkg::route_result_t route;
    logic [31:0]                     hi;
    logic [31:0]                     lo;
    route = expected_route(mode, tdest, epid);
    for (int i = 0; i < len; i++) begin
      hi = next_rand();
      lo = next_rand();
      beat.data = (i == 0) ? {hi, lo[15:0], epid} : {hi, lo};
      beat.last = (i == len - 1);
      exp_beat.push_back(beat);
      exp_route.push_back(route);
      @(negedge clk);
      i_s_tvalid = 1'b1;
      i_s_tdata  = beat.data;
      i_s_tlast  = beat.last;
      i_s_tmode  = mode;
      i_s_tdest  = tdest;
      do @(posedge clk); while (!o_s_tready);
    end
  endtask

  task automatic drain();
    @(negedge clk);
    i_s_tvalid = 1'b0;
    while (exp_beat.size() != 0) @(posedge clk);
    repeat (2) @(negedge clk);
  endtask

  // ----------------------------------------
  // Output side
  // ----------------------------------------

  // Random output stalls on about one cycle in four
  always @(negedge clk) begin
    if (rdy_random) begin
      rdy_state  = lcg_step(rdy_state);
      i_m_tready = (rdy_state[23:22] != 2'b00);
    end else begin
      i_m_tready = 1'b1;
    end
  end

  always @(posedge clk) begin : collect
    chdr_ingress_pkg::chdr_beat_t    beat;
    chdr_ingress_pkg::route_result_t route;
    if (!reset && o_m_tvalid && i_m_tready) begin
      if (exp_beat.size() == 0) begin
        errors++;
        $display("An output beat appeared while no packet was pending");
      end else begin
        beat  = exp_beat.pop_front();
        route = exp_route.pop_front();
        // First beat out needs its packet's last beat already in
        if (out_first && (in_pkts <= out_pkts)) begin
          errors++;
          $display("Packet %0d left before its last input beat was accepted", out_pkts);
        end
        check("o_m_tdata", beat.data, o_m_tdata);
        check("o_m_tlast", 64'(beat.last), 64'(o_m_tlast));
        check("o_m_tdest", 64'(route.port), 64'(o_m_tdest));
        check("o_m_tkeep", 64'(route.keep), 64'(o_m_tkeep));
      end
      out_first = o_m_tlast;
      if (o_m_tlast) out_pkts++;
    end
    if (!reset && i_s_tvalid && o_s_tready && i_s_tlast) in_pkts++;
  end

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  // Table is empty so an EPID packet misses
  task automatic test_reset_state();
    check("o_m_tvalid", 64'd0, 64'(o_m_tvalid));
    check("o_s_tready", 64'd1, 64'(o_s_tready));
    send_packet(2'd0, 4'd0, 16'h1234, 3);
    drain();
  endtask

  // Index 2 and 5 share an EPID
  // Index 1 is written invalid
  task automatic test_lookup_hit();
    write_route(3'd2, 1'b1, 16'h00a5, 4'd3);
    write_route(3'd5, 1'b1, 16'h00a5, 4'd7);
    write_route(3'd1, 1'b0, 16'h0777, 4'd1);
    write_route(3'd6, 1'b1, 16'h0777, 4'd12);
    send_packet(2'd0, 4'd0, 16'h00a5, 4);
    send_packet(2'd0, 4'd0, 16'h0777, 2);
    drain();
  endtask

  task automatic test_other_modes();
    send_packet(2'd1, 4'd5, 16'h00a5, 3);
    send_packet(2'd2, 4'd5, 16'h00a5, 2);
    send_packet(2'd3, 4'd6, 16'h0777, 1);
    drain();
  endtask

  task automatic test_store_forward();
    send_packet(2'd1, 4'd11, 16'h0042, 16);
    drain();
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    logic [15:0] epid;
    rdy_random = 1'b1;
    for (int p = 0; p < 20; p++) begin
      r    = next_rand();
      epid = (r[17:16] == 2'd0) ? 16'h00a5 : ((r[17:16] == 2'd1) ? 16'h0777 : r[31:16]);
      send_packet(r[9:8], r[13:10], epid, int'(r[4:0]) + 1);
    end
    drain();
    rdy_random = 1'b0;
  endtask

  initial begin : watchdog
    #(TEST_BEATS * 40 * CLK_PERIOD_NS);
    $display("Timeout: the tests did not finish within %0d ns",
             TEST_BEATS * 40 * CLK_PERIOD_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    i_s_tdata   = '0;
    i_s_tlast   = 1'b0;
    i_s_tmode   = 2'd0;
    i_s_tdest   = '0;
    i_s_tvalid  = 1'b0;
    i_cfg_wr    = 1'b0;
    i_cfg_index = '0;
    i_cfg_valid = 1'b0;
    i_cfg_epid  = '0;
    i_cfg_port  = '0;
    for (int i = 0; i < `ROUTE_ENTRIES; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_epid[i]  = '0;
      shadow_port[i]  = '0;
    end
    @(negedge reset);
    test_reset_state();
    test_lookup_hit();
    test_other_modes();
    test_store_forward();
    test_backpressure();
    // Protocol violations seen by the bound checker
    errors += i_dut.u_asserts.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
rtl/chdr_ingress_pkg.sv
rtl/axis_stream_if.sv
rtl/chdr_pkt_gate.sv
rtl/chdr_route_resolver.sv
rtl/chdr_dest_join.sv
rtl/chdr_ingress_top.sv
testbench/tb_clock_gen.sv
testbench/chdr_ingress_asserts.sv
testbench/chdr_ingress_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = chdr_ingress_tb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
